// ==== Makefile ====
TOP = mem_stage_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f mem_stage.f --top-module $(TOP) -o V$(TOP)

run: build
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

lint:
	verilator --lint-only --timing --assert -f mem_stage.f --top-module $(TOP)
	verilator --lint-only verilog/mem_stage_pkg.sv verilog/mem_resp_if.sv \
		verilog/mem_issue.sv verilog/load_return.sv verilog/mem_stage.sv \
		--top-module mem_stage

clean:
	rm -rf obj_dir

// ==== mem_stage.f ====
verilog/mem_stage_pkg.sv
verilog/mem_resp_if.sv
verilog/mem_issue.sv
verilog/load_return.sv
verilog/mem_stage.sv
testbench/dcache_sim.sv
testbench/mem_stage_sva.sv
testbench/mem_stage_tb.sv

// ==== testbench/dcache_sim.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_sim (
  input  logic                    clk,
  input  logic                    rst,
  // answer every access in its first strobe cycle
  input  logic                    zero_wait,
  input  logic                    read,
  input  logic                    write,
  input  mem_stage_pkg::word_t    address,
  input  mem_stage_pkg::word_t    wdata,
  input  mem_stage_pkg::byte_en_t mbe,
  output mem_stage_pkg::word_t    rdata,
  output logic                    resp
);
  import mem_stage_pkg::*;

  word_t mem [64];
  logic  busy;
  int    wait_left;

  // same fill as the testbench model, spread over the whole index
  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = (i * 32'h0101_0101) ^ 32'h5a3c_96e1 ^ (i << 20);
    end
    // quiet outputs before the first falling edge
    resp  = 1'b0;
    rdata = '0;
  end

  // respond on falling edges after a random delay
  always @(negedge clk) begin
    resp <= 1'b0;
    if (rst) begin
      busy = 1'b0;
      rdata <= '0;
    end else if (read || write) begin
      if (!busy) begin
        wait_left = zero_wait ? 0 : int'($urandom % 4);
        busy = 1'b1;
      end else begin
        wait_left = wait_left - 1;
      end
      if (wait_left == 0) begin
        busy = 1'b0;
        resp <= 1'b1;
        if (write) begin
          for (int l = 0; l < 4; l++) begin
            if (mbe[l]) begin
              mem[address[7:2]][l*8 +: 8] = wdata[l*8 +: 8];
            end
          end
        end
        rdata <= mem[address[7:2]];
      end
    end
  end

endmodule : dcache_sim

`default_nettype wire

// ==== testbench/mem_stage_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_sva (
  input logic                 clk,
  input logic                 rst,
  input logic                 stall,
  input logic                 dcache_read,
  input logic                 dcache_write,
  input mem_stage_pkg::word_t dcache_address,
  input logic                 dcache_resp,
  input logic                 wb_valid
);

  // an unanswered access keeps its kind and address
  assert property (@(posedge clk) disable iff (rst)
    ((dcache_read || dcache_write) && !dcache_resp) |=>
      ($stable(dcache_read) && $stable(dcache_write) && $stable(dcache_address)))
    else $error("access changed before the cache answered");

  // a paused cycle leaves a bubble in write-back
  assert property (@(posedge clk) disable iff (rst) stall |=> !wb_valid)
    else $error("write-back raised after a paused cycle");

  // stores complete without a write-back
  assert property (@(posedge clk) disable iff (rst)
    (dcache_write && dcache_resp) |=> !wb_valid)
    else $error("write-back raised after a store");

endmodule : mem_stage_sva

bind mem_stage mem_stage_sva u_sva (.*);

`default_nettype wire

// ==== testbench/mem_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;
  import mem_stage_pkg::*;

  localparam int    TIMEOUT = 50;
  localparam word_t BASE    = 32'h0000_1000;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic in_valid = 1'b0;
  logic in_write = 1'b0;
  mem_funct3_e in_funct3 = lw;
  word_t in_addr = '0;
  word_t in_wdata = '0;
  reg_addr_t in_rd = '0;
  logic zero_wait = 1'b0;
  logic stall, dcache_read, dcache_write, dcache_resp, wb_valid;
  word_t dcache_address, dcache_wdata, dcache_rdata, wb_data;
  byte_en_t dcache_mbe;
  reg_addr_t wb_rd;

  int errors = 0;
  int checks = 0;
  int accepted_loads = 0;
  int wb_count = 0;
  logic done_q = 1'b0;

  word_t model_mem [64];
  // accepted requests waiting for the cache
  logic pend_write[$];
  mem_funct3_e pend_f3[$];
  word_t pend_addr[$];
  word_t pend_data[$];
  reg_addr_t pend_rd[$];
  // expected write-backs in order
  reg_addr_t exp_rd[$];
  word_t exp_data[$];

  always #50 clk = ~clk;

  mem_stage DUT (.*);

  dcache_sim u_dcache (
    .clk(clk), .rst(rst), .zero_wait(zero_wait),
    .read(dcache_read), .write(dcache_write), .address(dcache_address),
    .wdata(dcache_wdata), .mbe(dcache_mbe), .rdata(dcache_rdata), .resp(dcache_resp)
  );

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // ************************************************************************
  // reference model
  // ************************************************************************

  function automatic word_t extract_load(word_t w, mem_funct3_e f, logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[off*8 +: 8];
    h = (off == 2'd3) ? 16'h0 : w[off*8 +: 16];
    case (f)
      lb:  return {{24{b[7]}}, b};
      lbu: return {24'h0, b};
      lh:  return (off == 2'd3) ? HALF_MISALIGN_FILL : {{16{h[15]}}, h};
      lhu: return (off == 2'd3) ? HALF_MISALIGN_FILL : {16'h0, h};
      default: return w;
    endcase
  endfunction

  function automatic byte_en_t store_mask(mem_funct3_e f, logic [1:0] off);
    case (f)
      sb: return 4'b0001 << off;
      sh: return 4'((6'b000011 << off) & 6'b001111);
      default: return 4'b1111;
    endcase
  endfunction

  // store bytes placed in their lanes
  function automatic word_t store_lanes(mem_funct3_e f, logic [1:0] off, word_t d);
    word_t w;
    w = '0;
    case (f)
      sb: w[off*8 +: 8] = d[7:0];
      sh: begin
        w[off*8 +: 8] = d[7:0];
        if (off != 2'd3) w[off*8+8 +: 8] = d[15:8];
      end
      default: w = d;
    endcase
    return w;
  endfunction

  // ************************************************************************
  // monitor, sampled at the rising edge
  // ************************************************************************

  always @(posedge clk) begin : monitor
    logic        w;
    logic        load_seen;
    mem_funct3_e f;
    word_t       a, d, m32;
    reg_addr_t   r;
    byte_en_t    m;
    if (rst) begin
      done_q = 1'b0;
    end else begin
      load_seen = 1'b0;
      check_val("wb_valid_after_completion", 32'(done_q), 32'(wb_valid));
      // a request sits in ex/mem until its response
      check_val("stall", 32'((pend_addr.size() != 0) && !dcache_resp), 32'(stall));
      if (wb_valid) begin
        wb_count++;
        if (exp_rd.size() == 0) begin
          $display("ERROR: write-back seen with no load outstanding");
          errors++;
        end else begin
          check_val("wb_rd", 32'(exp_rd.pop_front()), 32'(wb_rd));
          check_val("wb_data", exp_data.pop_front(), wb_data);
        end
      end
      if (zero_wait && stall) begin
        $display("ERROR: stall raised during the zero-wait load run");
        errors++;
      end
      if (dcache_resp && (dcache_read || dcache_write)) begin
        if (pend_addr.size() == 0) begin
          $display("ERROR: cache access completed with no request accepted");
          errors++;
        end else begin
          w = pend_write.pop_front();
          f = pend_f3.pop_front();
          a = pend_addr.pop_front();
          d = pend_data.pop_front();
          r = pend_rd.pop_front();
          check_val("dcache_address", {a[31:2], 2'b00}, dcache_address);
          check_val("dcache_read", 32'(!w), 32'(dcache_read));
          check_val("dcache_write", 32'(w), 32'(dcache_write));
          if (w) begin
            m = store_mask(f, a[1:0]);
            m32 = {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
            check_val("store_mbe", 32'(m), 32'(dcache_mbe));
            check_val("store_lanes", store_lanes(f, a[1:0], d) & m32, dcache_wdata & m32);
            model_mem[a[7:2]] = (model_mem[a[7:2]] & ~m32) | (store_lanes(f, a[1:0], d) & m32);
          end else begin
            check_val("load_mbe", 32'hf, 32'(dcache_mbe));
            exp_rd.push_back(r);
            exp_data.push_back(extract_load(model_mem[a[7:2]], f, a[1:0]));
            load_seen = 1'b1;
          end
        end
      end
      done_q = load_seen;
      if (in_valid && !stall) begin
        pend_write.push_back(in_write);
        pend_f3.push_back(in_funct3);
        pend_addr.push_back(in_addr);
        pend_data.push_back(in_wdata);
        pend_rd.push_back(in_rd);
        if (!in_write) accepted_loads++;
      end
    end
  end

  // ************************************************************************
  // stimulus
  // ************************************************************************

  task automatic issue_req(input logic w, input mem_funct3_e f, input word_t a,
                           input word_t d, input reg_addr_t r);
    int guard;
    guard = 0;
    @(negedge clk);
    in_valid = 1'b1;
    in_write = w;
    in_funct3 = f;
    in_addr = a;
    in_wdata = d;
    in_rd = r;
    @(posedge clk);
    while (stall) begin
      guard++;
      if (guard > TIMEOUT) begin
        $display("ERROR: request was not accepted within %0d cycles", TIMEOUT);
        errors++;
        break;
      end
      @(posedge clk);
    end
  endtask

  task automatic go_idle();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic drain();
    int guard;
    guard = 0;
    while (pend_addr.size() != 0 || exp_rd.size() != 0) begin
      guard++;
      if (guard > TIMEOUT) begin
        $display("ERROR: outstanding requests did not finish within %0d cycles", TIMEOUT);
        errors++;
        break;
      end
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic check_quiet(input string name);
    check_val({name, "_stall"}, 32'd0, 32'(stall));
    check_val({name, "_dcache_read"}, 32'd0, 32'(dcache_read));
    check_val({name, "_dcache_write"}, 32'd0, 32'(dcache_write));
    check_val({name, "_wb_valid"}, 32'd0, 32'(wb_valid));
    check_val({name, "_dcache_mbe"}, 32'd0, 32'(dcache_mbe));
  endtask

  function automatic mem_funct3_e rand_f3(logic w);
    case (w ? $urandom % 3 : $urandom % 5)
      0: return lb;
      1: return lh;
      2: return lw;
      3: return lbu;
      default: return lhu;
    endcase
  endfunction

  initial begin
    mem_funct3_e store_ops[3];
    mem_funct3_e load_ops[5];
    logic        w;
    store_ops = '{sb, sh, sw};
    load_ops = '{lb, lbu, lh, lhu, lw};
    void'($urandom(32'hd92d41b9));
    for (int i = 0; i < 64; i++) begin
      model_mem[i] = (i * 32'h0101_0101) ^ 32'h5a3c_96e1 ^ (i << 20);
    end
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      @(negedge clk);
      check_quiet("reset");
    end
    rst = 1'b0;
    @(negedge clk);
    check_quiet("after_reset");

    // every store and load kind at every offset
    for (int off = 0; off < 4; off++) begin
      for (int s = 0; s < 3; s++) begin
        issue_req(1'b1, store_ops[s], BASE + 32'h40 + off, $urandom, '0);
        for (int l = 0; l < 5; l++) begin
          issue_req(1'b0, load_ops[l], BASE + 32'h40 + off, '0, reg_addr_t'($urandom));
        end
      end
    end
    go_idle();
    drain();

    // random mix under random delays and idle gaps
    for (int n = 0; n < 400; n++) begin
      if ($urandom % 4 == 0) go_idle();
      w = 1'($urandom);
      issue_req(w, rand_f3(w), BASE + ($urandom % 256), $urandom, reg_addr_t'($urandom));
    end
    go_idle();
    drain();

    // back-to-back loads with a zero-wait cache
    zero_wait = 1'b1;
    for (int n = 0; n < 40; n++) begin
      issue_req(1'b0, rand_f3(1'b0), BASE + ($urandom % 256), '0, reg_addr_t'($urandom));
    end
    go_idle();
    drain();
    zero_wait = 1'b0;

    check_val("writeback_count", accepted_loads, wb_count);
    $display("checks %0d, errors %0d, loads %0d, write-backs %0d",
             checks, errors, accepted_loads, wb_count);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : mem_stage_tb

`default_nettype wire

// ==== verilog/load_return.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_return (
  input  logic                     clk,
  input  logic                     rst,

  // raw word from the data cache
  input  mem_stage_pkg::word_t     dcache_rdata,

  // completing access from the issue side
  mem_resp_if.ret                  resp,

  // write-back port
  output logic                     wb_valid,
  output mem_stage_pkg::reg_addr_t wb_rd,
  output mem_stage_pkg::word_t     wb_data
);
  import mem_stage_pkg::*;

  logic [4:0] lane_shift;
  word_t      rdata_shifted;
  logic [7:0] sel_byte;
  logic [15:0] sel_half;
  logic       half_misaligned;
  word_t      load_data;

  // ************************************************************************
  // load extraction
  // ************************************************************************

  // bring the addressed lane down to bit 0
  assign lane_shift    = {resp.offset, 3'b000};
  assign rdata_shifted = dcache_rdata >> lane_shift;
  assign sel_byte      = rdata_shifted[7:0];
  assign sel_half      = rdata_shifted[15:0];

  // a halfword at offset 3 would cross into the next word
  assign half_misaligned = (resp.offset == 2'd3);

  always_comb begin
    case (resp.funct3)
      lb: begin
        load_data = {{24{sel_byte[7]}}, sel_byte};
      end
      lbu: begin
        load_data = {24'd0, sel_byte};
      end
      lh: begin
        if (half_misaligned) begin
          load_data = HALF_MISALIGN_FILL;
        end else begin
          load_data = {{16{sel_half[15]}}, sel_half};
        end
      end
      lhu: begin
        if (half_misaligned) begin
          load_data = HALF_MISALIGN_FILL;
        end else begin
          load_data = {16'd0, sel_half};
        end
      end
      default: begin
        // lw, word is already aligned
        load_data = dcache_rdata;
      end
    endcase
  end

  // ************************************************************************
  // mem/wb register
  // ************************************************************************

  // paused cycles leave a bubble here
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= resp.load_done;
    end
  end

  // payload is only meaningful with wb_valid
  always_ff @(posedge clk) begin
    wb_rd   <= resp.rd;
    wb_data <= load_data;
  end

endmodule : load_return

`default_nettype wire

// ==== verilog/mem_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_issue (
  input  logic                       clk,
  input  logic                       rst,

  // request from the execute stage
  input  logic                       in_valid,
  input  logic                       in_write,
  input  mem_stage_pkg::mem_funct3_e in_funct3,
  input  mem_stage_pkg::word_t       in_addr,
  input  mem_stage_pkg::word_t       in_wdata,
  input  mem_stage_pkg::reg_addr_t   in_rd,

  // pipeline hold level
  output logic                       stall,

  // data cache side
  output logic                       dcache_read,
  output logic                       dcache_write,
  output mem_stage_pkg::word_t       dcache_address,
  output mem_stage_pkg::word_t       dcache_wdata,
  output mem_stage_pkg::byte_en_t    dcache_mbe,
  input  logic                       dcache_resp,

  // completing access toward load return
  mem_resp_if.issue                  resp
);
  import mem_stage_pkg::*;

  // ex/mem request register
  logic         req_valid;
  logic         req_write;
  mem_funct3_e  req_funct3;
  word_t        req_addr;
  word_t        req_wdata;
  reg_addr_t    req_rd;

  byte_offset_t req_offset;
  logic [4:0]   lane_shift;
  word_t        shifted_wdata;
  byte_en_t     store_mbe;
  word_t        store_wdata;

  // ************************************************************************
  // request register
  // ************************************************************************

  // valid bit takes the input whenever the stage is not held
  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
    end else if (!stall) begin
      req_valid <= in_valid;
    end
  end

  // payload follows the same load condition
  always_ff @(posedge clk) begin
    if (!stall) begin
      req_write  <= in_write;
      req_funct3 <= in_funct3;
      req_addr   <= in_addr;
      req_wdata  <= in_wdata;
      req_rd     <= in_rd;
    end
  end

  // held until the cache answers
  assign stall = req_valid & ~dcache_resp;

  // ************************************************************************
  // store lane alignment
  // ************************************************************************

  assign req_offset    = req_addr[1:0];
  // eight bits per byte position
  assign lane_shift    = {req_offset, 3'b000};
  assign shifted_wdata = req_wdata << lane_shift;

  always_comb begin
    case (req_funct3)
      sb: begin
        store_wdata = shifted_wdata;
        store_mbe   = MBE_BYTE << req_offset;
      end
      sh: begin
        // upper lane drops out at offset 3
        store_wdata = shifted_wdata;
        store_mbe   = MBE_HALF << req_offset;
      end
      default: begin
        store_wdata = req_wdata;
        store_mbe   = MBE_WORD;
      end
    endcase
  end

  // ************************************************************************
  // cache strobes
  // ************************************************************************

  assign dcache_read    = req_valid & ~req_write;
  assign dcache_write   = req_valid & req_write;
  assign dcache_address = {req_addr[XLEN-1:2], 2'b00};
  assign dcache_wdata   = store_wdata;

  // loads read the full word, idle stage enables nothing
  always_comb begin
    if (!req_valid) begin
      dcache_mbe = '0;
    end else if (req_write) begin
      dcache_mbe = store_mbe;
    end else begin
      dcache_mbe = MBE_WORD;
    end
  end

  // ************************************************************************
  // completion toward load return
  // ************************************************************************

  assign resp.load_done = dcache_read & dcache_resp;
  assign resp.funct3    = req_funct3;
  assign resp.offset    = req_offset;
  assign resp.rd        = req_rd;

endmodule : mem_issue

`default_nettype wire

// ==== verilog/mem_resp_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_resp_if;
  import mem_stage_pkg::*;

  // high in the cycle a load gets its cache response
  logic         load_done;
  // width code and byte position of the completing load
  mem_funct3_e  funct3;
  byte_offset_t offset;
  // destination register for write-back
  reg_addr_t    rd;

  modport issue (
    output load_done,
    output funct3,
    output offset,
    output rd
  );

  modport ret (
    input load_done,
    input funct3,
    input offset,
    input rd
  );

endinterface : mem_resp_if

`default_nettype wire

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic                       clk,
  input  logic                       rst,

  // request from the execute stage
  input  logic                       in_valid,
  input  logic                       in_write,
  input  mem_stage_pkg::mem_funct3_e in_funct3,
  input  mem_stage_pkg::word_t       in_addr,
  input  mem_stage_pkg::word_t       in_wdata,
  input  mem_stage_pkg::reg_addr_t   in_rd,

  // held while the cache is busy
  output logic                       stall,

  // data cache
  output logic                       dcache_read,
  output logic                       dcache_write,
  output mem_stage_pkg::word_t       dcache_address,
  output mem_stage_pkg::word_t       dcache_wdata,
  output mem_stage_pkg::byte_en_t    dcache_mbe,
  input  mem_stage_pkg::word_t       dcache_rdata,
  input  logic                       dcache_resp,

  // write-back
  output logic                       wb_valid,
  output mem_stage_pkg::reg_addr_t   wb_rd,
  output mem_stage_pkg::word_t       wb_data
);

  // completing access, issue to return
  mem_resp_if u_resp_if ();

  mem_issue u_issue (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_write       (in_write),
    .in_funct3      (in_funct3),
    .in_addr        (in_addr),
    .in_wdata       (in_wdata),
    .in_rd          (in_rd),
    .stall          (stall),
    .dcache_read    (dcache_read),
    .dcache_write   (dcache_write),
    .dcache_address (dcache_address),
    .dcache_wdata   (dcache_wdata),
    .dcache_mbe     (dcache_mbe),
    .dcache_resp    (dcache_resp),
    .resp           (u_resp_if.issue)
  );

  load_return u_load_return (
    .clk          (clk),
    .rst          (rst),
    .dcache_rdata (dcache_rdata),
    .resp         (u_resp_if.ret),
    .wb_valid     (wb_valid),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data)
  );

endmodule : mem_stage

`default_nettype wire

// ==== verilog/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

  // ************************************************************************
  // widths
  // ************************************************************************

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // data word, also used for byte addresses
  typedef logic [XLEN-1:0] word_t;

  // destination register index
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // byte position inside a word
  typedef logic [1:0] byte_offset_t;

  // one enable bit per byte lane
  typedef logic [XLEN/8-1:0] byte_en_t;

  // ************************************************************************
  // funct3 width codes
  // ************************************************************************

  // load encodings as in the RV32I spec
  typedef enum logic [2:0] {
    lb  = 3'd0,
    lh  = 3'd1,
    lw  = 3'd2,
    lbu = 3'd4,
    lhu = 3'd5
  } mem_funct3_e;

  // stores reuse the low three codes
  localparam mem_funct3_e sb = lb;
  localparam mem_funct3_e sh = lh;
  localparam mem_funct3_e sw = lw;

  // ************************************************************************
  // lane masks and fill value
  // ************************************************************************

  // base masks before shifting to the addressed lane
  localparam byte_en_t MBE_BYTE = 4'b0001;
  localparam byte_en_t MBE_HALF = 4'b0011;
  localparam byte_en_t MBE_WORD = 4'b1111;

  // halfword crossing the word boundary has no defined result,
  // so a recognizable pattern is returned instead
  localparam word_t HALF_MISALIGN_FILL = 32'hBAADBAAD;

endpackage : mem_stage_pkg

`default_nettype wire
